// ==== wr_path_pkg.sv ====
package wr_path_pkg;

    ////////////////////////////////////////////////////////////
    // bus and channel sizes
    ////////////////////////////////////////////////////////////
    localparam int NUM_CHAN   = 4;      // write channels
    localparam int USER_W     = 32;     // user word width
    localparam int AXI_W      = 64;     // bus data width
    localparam int AXI_BYTES  = 8;      // bytes per beat
    localparam int ADDR_W     = 30;     // byte address width

    localparam int FIFO_DEPTH = 16;     // beats per channel
    localparam int FIFO_AW    = 4;      // log2 of depth

    ////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////
    typedef logic [USER_W-1:0]  user_word_t;
    typedef logic [ADDR_W-1:0]  axi_addr_t;

    // beats in a burst are len + 1
    typedef logic [7:0]         burst_len_t;

    // fill level, one bit wider than the pointer so 16 fits
    typedef logic [FIFO_AW:0]   beat_cnt_t;

    // one bus beat, either the raw word or two user lanes
    typedef union packed {
        logic [AXI_W-1:0]       word;
        user_word_t [1:0]       lane;   // lane 0 is the low half, earlier word
    } axi_beat_u;

endpackage

// ==== wr_req_if.sv ====
`timescale 1ns/1ns

interface wr_req_if;
    import wr_path_pkg::*;

    logic       req;    // enough beats buffered for one burst
    logic       grant;  // held until the burst is done
    axi_addr_t  addr;   // start of this channel's next burst
    burst_len_t len;    // awlen for the burst
    axi_beat_u  data;   // fifo head beat
    logic       pop;    // one W beat accepted

    modport chan (
        output req,
        output addr,
        output len,
        output data,
        input  grant,
        input  pop
    );

    modport arb (
        input  req,
        input  addr,
        input  len,
        input  data,
        output grant,
        output pop
    );

endinterface

// ==== wr_chan_fifo.sv ====
`timescale 1ns/1ns

module wr_chan_fifo (
    input  logic                    wr_clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  wr_path_pkg::user_word_t wr_data,
    input  logic                    pop,
    output wr_path_pkg::axi_beat_u  head,
    output wr_path_pkg::beat_cnt_t  count,
    output logic                    full
);
    import wr_path_pkg::*;

    ////////////////////////////////////////////////////////////
    // word pair packer
    ////////////////////////////////////////////////////////////
    user_word_t         lo_word;        // first word of a pair
    logic               lo_vld;         // lone word waiting for its partner
    axi_beat_u          pack_beat;
    logic               pack_vld;       // beat ready to go into memory

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            lo_vld   <= 1'b0;
            pack_vld <= 1'b0;
        end else begin
            pack_vld <= wr_en & lo_vld;     // pair completes on this word
            if (wr_en) begin
                lo_vld <= ~lo_vld;
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_en && !lo_vld) begin
            lo_word <= wr_data;
        end
        if (wr_en && lo_vld) begin
            pack_beat.lane[0] <= lo_word;   // earlier word low
            pack_beat.lane[1] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // beat memory, show-ahead read
    ////////////////////////////////////////////////////////////
    axi_beat_u          mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               push;
    logic               pop_ok;

    assign full   = (count == beat_cnt_t'(FIFO_DEPTH));
    assign push   = pack_vld & ~full;       // completed pair lost when full
    assign pop_ok = pop & (count != '0);
    assign head   = mem[rd_ptr];            // oldest beat always visible

    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_ptr] <= pack_beat;
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none or both
            endcase
        end
    end

endmodule

// ==== wr_channel_ctrl.sv ====
`timescale 1ns/1ns

module wr_channel_ctrl (
    input  logic                    wr_clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  wr_path_pkg::user_word_t wr_data,
    input  wr_path_pkg::axi_addr_t  beg_addr,
    input  wr_path_pkg::axi_addr_t  end_addr,
    input  wr_path_pkg::burst_len_t burst_len,
    output logic                    wr_full,
    wr_req_if.chan                  req_port
);
    import wr_path_pkg::*;

    beat_cnt_t  count;
    axi_addr_t  offset;         // next burst start, relative to beg_addr
    axi_addr_t  burst_bytes;
    axi_addr_t  next_offset;
    logic       wrap;
    logic       grant_d;
    logic       burst_end;
    logic       enough;

    wr_chan_fifo u_fifo (
        .wr_clk  (wr_clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .pop     (req_port.pop),
        .head    (req_port.data),
        .count   (count),
        .full    (wr_full)
    );

    ////////////////////////////////////////////////////////////
    // burst address walk
    ////////////////////////////////////////////////////////////
    assign burst_bytes = (axi_addr_t'(burst_len) + 1'b1) * axi_addr_t'(AXI_BYTES);
    assign next_offset = offset + burst_bytes;

    // following burst must end inside the region
    assign wrap = (beg_addr + next_offset + burst_bytes - 1'b1) > end_addr;

    assign burst_end = grant_d & ~req_port.grant;   // grant just dropped

    // count >= len + 1
    assign enough = 9'(count) > 9'(burst_len);

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            offset       <= '0;
            grant_d      <= 1'b0;
            req_port.req <= 1'b0;
        end else begin
            grant_d      <= req_port.grant;
            req_port.req <= enough & ~req_port.grant;
            if (burst_end) begin
                offset <= wrap ? '0 : next_offset;  // back to region start
            end
        end
    end

    assign req_port.addr = beg_addr + offset;   // stable while granted
    assign req_port.len  = burst_len;

endmodule

// ==== wr_arbiter.sv ====
`timescale 1ns/1ns

module wr_arbiter (
    input  logic                    wr_clk,
    input  logic                    rst_n,
    wr_req_if.arb                   chan [wr_path_pkg::NUM_CHAN],
    input  logic                    wr_done,
    input  logic                    beat_accept,
    output logic                    wr_start,
    output wr_path_pkg::axi_addr_t  wr_addr,
    output wr_path_pkg::burst_len_t wr_len,
    output wr_path_pkg::axi_beat_u  wr_data_out
);
    import wr_path_pkg::*;

    logic [NUM_CHAN-1:0]         req_vec;
    logic [NUM_CHAN-1:0]         grant_vec;
    axi_addr_t                   addr_arr [NUM_CHAN];
    burst_len_t                  len_arr  [NUM_CHAN];
    axi_beat_u                   data_arr [NUM_CHAN];
    logic [$clog2(NUM_CHAN)-1:0] last_ptr;      // last granted channel
    logic [$clog2(NUM_CHAN)-1:0] next_ptr;
    logic [$clog2(NUM_CHAN)-1:0] cand;
    logic                        found;
    logic                        busy;

    // flatten the interface array
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        assign req_vec[i]    = chan[i].req;
        assign addr_arr[i]   = chan[i].addr;
        assign len_arr[i]    = chan[i].len;
        assign data_arr[i]   = chan[i].data;
        assign chan[i].grant = grant_vec[i];
        assign chan[i].pop   = grant_vec[i] & beat_accept;  // W beat to granted fifo
    end

    ////////////////////////////////////////////////////////////
    // round-robin pick, starting after last_ptr
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_ptr = last_ptr;
        found    = 1'b0;
        cand     = last_ptr;
        for (int i = 1; i <= NUM_CHAN; i++) begin
            cand = last_ptr + i[$clog2(NUM_CHAN)-1:0];  // wraps around
            if (!found && req_vec[cand]) begin
                next_ptr = cand;
                found    = 1'b1;
            end
        end
    end

    assign busy = |grant_vec;

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_vec <= '0;
            wr_start  <= 1'b0;
            last_ptr  <= '1;                // so channel 0 wins first
        end else begin
            wr_start <= 1'b0;
            if (busy) begin
                if (wr_done) begin
                    grant_vec <= '0;        // idle for one cycle after this
                end
            end else if (found) begin
                grant_vec <= NUM_CHAN'(1) << next_ptr;
                last_ptr  <= next_ptr;
                wr_start  <= 1'b1;
            end
        end
    end

    // route the granted channel to the master
    assign wr_addr     = addr_arr[last_ptr];
    assign wr_len      = len_arr[last_ptr];
    assign wr_data_out = data_arr[last_ptr];

endmodule

// ==== axi_wr_master.sv ====
`timescale 1ns/1ns

module axi_wr_master (
    input  logic                         wr_clk,
    input  logic                         rst_n,
    input  logic                         wr_start,
    input  wr_path_pkg::axi_addr_t       wr_addr,
    input  wr_path_pkg::burst_len_t      wr_len,
    input  wr_path_pkg::axi_beat_u       wr_data_in,
    output logic                         beat_accept,
    output logic                         wr_done,
    // AW channel
    output wr_path_pkg::axi_addr_t       awaddr,
    output wr_path_pkg::burst_len_t      awlen,
    output logic                         awvalid,
    input  logic                         awready,
    // W channel
    output logic [wr_path_pkg::AXI_W-1:0] wdata,
    output logic                         wlast,
    output logic                         wvalid,
    input  logic                         wready,
    // B channel
    input  logic                         bvalid,
    output logic                         bready
);
    import wr_path_pkg::*;

    enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } state;

    burst_len_t beat_cnt;       // W handshakes so far in this burst

    assign beat_accept = wvalid & wready;
    assign wdata       = wr_data_in.word;   // fifo head, held until popped

    // burst descriptor, taken at start
    always_ff @(posedge wr_clk) begin
        if (state == S_IDLE && wr_start) begin
            awaddr <= wr_addr;
            awlen  <= wr_len;
        end
    end

    ////////////////////////////////////////////////////////////
    // write FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            wlast    <= 1'b0;
            bready   <= 1'b0;
            wr_done  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (wr_start) begin
                        awvalid <= 1'b1;
                        state   <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (awready) begin              // AW handshake
                        awvalid  <= 1'b0;
                        wvalid   <= 1'b1;
                        wlast    <= (awlen == '0);  // single beat burst
                        beat_cnt <= '0;
                        state    <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (wready) begin
                        if (wlast) begin
                            wvalid <= 1'b0;
                            wlast  <= 1'b0;
                            bready <= 1'b1;
                            state  <= S_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            wlast    <= (beat_cnt + 1'b1 == awlen);
                        end
                    end
                end
                S_RESP: begin
                    if (bvalid) begin               // response not checked
                        bready  <= 1'b0;
                        wr_done <= 1'b1;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== multichannel_wr_top.sv ====
`timescale 1ns/1ns

module multichannel_wr_top (
    input  logic                                                wr_clk,
    input  logic                                                rst_n,
    input  logic [wr_path_pkg::NUM_CHAN-1:0]                    wr_en,
    input  wr_path_pkg::user_word_t [wr_path_pkg::NUM_CHAN-1:0] wr_data,
    input  wr_path_pkg::axi_addr_t  [wr_path_pkg::NUM_CHAN-1:0] beg_addr,
    input  wr_path_pkg::axi_addr_t  [wr_path_pkg::NUM_CHAN-1:0] end_addr,
    input  wr_path_pkg::burst_len_t [wr_path_pkg::NUM_CHAN-1:0] burst_len,
    output logic [wr_path_pkg::NUM_CHAN-1:0]                    wr_full,
    output wr_path_pkg::axi_addr_t                              awaddr,
    output wr_path_pkg::burst_len_t                             awlen,
    output logic                                                awvalid,
    input  logic                                                awready,
    output logic [wr_path_pkg::AXI_W-1:0]                       wdata,
    output logic                                                wlast,
    output logic                                                wvalid,
    input  logic                                                wready,
    input  logic                                                bvalid,
    output logic                                                bready
);
    import wr_path_pkg::*;

    logic       wr_start;
    axi_addr_t  wr_addr;
    burst_len_t wr_len;
    axi_beat_u  wr_data_in;     // routed head beat
    logic       beat_accept;
    logic       wr_done;

    wr_req_if req_if [NUM_CHAN] ();

    ////////////////////////////////////////////////////////////
    // channels
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        wr_channel_ctrl u_chan (
            .wr_clk    (wr_clk),
            .rst_n     (rst_n),
            .wr_en     (wr_en[i]),
            .wr_data   (wr_data[i]),
            .beg_addr  (beg_addr[i]),
            .end_addr  (end_addr[i]),
            .burst_len (burst_len[i]),
            .wr_full   (wr_full[i]),
            .req_port  (req_if[i])
        );
    end

    wr_arbiter u_arb (
        .wr_clk      (wr_clk),
        .rst_n       (rst_n),
        .chan        (req_if),
        .wr_done     (wr_done),
        .beat_accept (beat_accept),
        .wr_start    (wr_start),
        .wr_addr     (wr_addr),
        .wr_len      (wr_len),
        .wr_data_out (wr_data_in)
    );

    axi_wr_master u_master (
        .wr_clk      (wr_clk),
        .rst_n       (rst_n),
        .wr_start    (wr_start),
        .wr_addr     (wr_addr),
        .wr_len      (wr_len),
        .wr_data_in  (wr_data_in),
        .beat_accept (beat_accept),
        .wr_done     (wr_done),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready)
    );

endmodule

// ==== tb_multichannel_wr.sv ====
`timescale 1ns/1ns

module tb_multichannel_wr;
    import wr_path_pkg::*;

    localparam int TIMEOUT = 3000;      // cycles allowed per wait
    localparam int M_READY = 0;         // slave always ready
    localparam int M_HOLD  = 1;         // awready held low
    localparam int M_RAND  = 2;         // random back-pressure

    logic                      wr_clk;
    logic                      rst_n;
    logic [NUM_CHAN-1:0]       wr_en;
    user_word_t [NUM_CHAN-1:0] wr_data;
    axi_addr_t  [NUM_CHAN-1:0] beg_addr;
    axi_addr_t  [NUM_CHAN-1:0] end_addr;
    burst_len_t [NUM_CHAN-1:0] burst_len;
    logic [NUM_CHAN-1:0]       wr_full;
    axi_addr_t                 awaddr;
    burst_len_t                awlen;
    logic                      awvalid;
    logic                      awready;
    logic [AXI_W-1:0]          wdata;
    logic                      wlast;
    logic                      wvalid;
    logic                      wready;
    logic                      bvalid;
    logic                      bready;

    user_word_t ref_q [NUM_CHAN][$];    // words still expected per channel
    int         aw_chan_q [$];
    axi_addr_t  aw_addr_q [$];
    burst_len_t aw_len_q [$];
    int         slave_mode;
    int         resp_pend;              // bursts waiting for a B response
    int         done_cnt;
    int         beat_cnt;
    int         cur_chan;
    int         cur_len;
    int         beat_idx;
    int         err_cnt;
    int         test_cnt;
    int         fail_cnt;

    multichannel_wr_top UUT (.*);

    initial begin
        wr_clk = 1'b0;
        forever #4 wr_clk = ~wr_clk;
    end

    ////////////////////////////////////////////////////////////
    // AXI slave model
    ////////////////////////////////////////////////////////////
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(negedge wr_clk);
            case (slave_mode)
                M_READY: begin
                    awready = 1'b1;
                    wready  = 1'b1;
                end
                M_HOLD: begin
                    awready = 1'b0;
                    wready  = 1'b1;
                end
                default: begin
                    awready = 1'($urandom_range(1, 0));
                    wready  = 1'($urandom_range(1, 0));
                end
            endcase
            if (resp_pend == 0) begin
                bvalid = 1'b0;
            end else if (!bvalid) begin
                bvalid = (slave_mode != M_RAND) || ($urandom_range(3, 0) == 0);  // random delay
            end
        end
    end

    always @(posedge wr_clk) begin : bus_monitor
        user_word_t w0;
        user_word_t w1;
        if (rst_n) begin
            if (awvalid && awready) begin
                cur_chan = find_chan(awaddr);   // region decides the channel
                cur_len  = (cur_chan >= 0) ? int'(burst_len[cur_chan]) : -1;
                beat_idx = 0;
                aw_chan_q.push_back(cur_chan);
                aw_addr_q.push_back(awaddr);
                aw_len_q.push_back(awlen);
                assert (cur_chan >= 0) else begin
                    $display("error at %0t: awaddr %0h is outside every region", $time, awaddr);
                    err_cnt++;
                end
                if (cur_chan >= 0) begin
                    check_value("awlen", awlen, cur_len);
                end
            end
            if (wvalid && wready) begin
                check_value("wlast", wlast, beat_idx == cur_len);
                if (cur_chan >= 0) begin
                    assert (ref_q[cur_chan].size() >= 2) begin
                        w0 = ref_q[cur_chan].pop_front();
                        w1 = ref_q[cur_chan].pop_front();
                        check_value("wdata[31:0]", wdata[31:0], w0);     // earlier word low
                        check_value("wdata[63:32]", wdata[63:32], w1);
                    end else begin
                        $display("error at %0t: beat on channel %0d with no data left to send",
                                 $time, cur_chan);
                        err_cnt++;
                    end
                end
                beat_idx++;
                beat_cnt++;
                if (wlast) begin
                    resp_pend++;
                end
            end
            if (bvalid && bready) begin
                resp_pend--;
                done_cnt++;
            end
        end
    end

    function automatic int find_chan(input axi_addr_t addr);
        int ch;
        ch = -1;
        for (int i = NUM_CHAN - 1; i >= 0; i--) begin
            if (addr >= beg_addr[i] && addr <= end_addr[i]) begin
                ch = i;
            end
        end
        return ch;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic do_reset();
        rst_n = 1'b0;
        wr_en = '0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            ref_q[i].delete();
        end
        aw_chan_q.delete();
        aw_addr_q.delete();
        aw_len_q.delete();
        resp_pend = 0;
        done_cnt  = 0;
        beat_cnt  = 0;
        cur_chan  = -1;
        repeat (5) @(negedge wr_clk);
        rst_n = 1'b1;
    endtask

    // n words on every channel in mask, one per cycle
    task automatic send_words(input logic [NUM_CHAN-1:0] mask, input int n, input bit keep);
        user_word_t w;
        for (int k = 0; k < n; k++) begin
            @(negedge wr_clk);
            for (int i = 0; i < NUM_CHAN; i++) begin
                w = $urandom;
                wr_data[i] = w;
                if (mask[i] && keep) begin
                    ref_q[i].push_back(w);
                end
            end
            wr_en = mask;
        end
        @(negedge wr_clk);
        wr_en = '0;
    endtask

    task automatic wait_bursts(input int n);
        int cyc;
        cyc = 0;
        while (done_cnt < n && cyc < TIMEOUT) begin
            @(negedge wr_clk);
            cyc++;
        end
        assert (done_cnt >= n) else begin
            $display("error at %0t: timed out waiting for burst %0d to finish", $time, n);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt != errs_before) begin
            fail_cnt++;
            $display("%0t test %s: FAIL with %0d errors", $time, name, err_cnt - errs_before);
        end else begin
            $display("%0t test %s: ok", $time, name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        int e0;
        e0 = err_cnt;
        do_reset();
        @(negedge wr_clk);
        check_value("awvalid", awvalid, 0);
        check_value("wvalid", wvalid, 0);
        check_value("wlast", wlast, 0);
        check_value("bready", bready, 0);
        check_value("wr_full", wr_full, 0);
        end_test("reset state", e0);
    endtask

    task automatic test_single_burst();
        int e0;
        e0 = err_cnt;
        slave_mode = M_READY;
        burst_len[0] = 8'd3;
        do_reset();
        send_words(4'b0001, 8, 1'b1);
        wait_bursts(1);
        check_value("aw count", aw_addr_q.size(), 1);
        if (aw_addr_q.size() == 1) begin
            check_value("awaddr", aw_addr_q[0], beg_addr[0]);
            check_value("awlen", aw_len_q[0], 3);
        end
        check_value("beat count", beat_cnt, 4);
        check_value("words left ch0", ref_q[0].size(), 0);
        end_test("single burst and packing", e0);
    endtask

    task automatic test_addr_wrap();
        int        e0;
        axi_addr_t step;
        e0 = err_cnt;
        step = axi_addr_t'(4 * AXI_BYTES);             // len 3 burst in bytes
        burst_len[1] = 8'd3;
        end_addr[1]  = beg_addr[1] + 2 * step - 1'b1;  // room for two bursts
        do_reset();
        send_words(4'b0010, 24, 1'b1);
        wait_bursts(3);
        check_value("aw count", aw_addr_q.size(), 3);
        if (aw_addr_q.size() == 3) begin
            check_value("awaddr burst 0", aw_addr_q[0], beg_addr[1]);
            check_value("awaddr burst 1", aw_addr_q[1], beg_addr[1] + step);
            check_value("awaddr burst 2", aw_addr_q[2], beg_addr[1]);
        end
        end_addr[1] = beg_addr[1] + 30'h0ffff;
        end_test("address advance and wrap", e0);
    endtask

    task automatic test_round_robin();
        int e0;
        int cyc;
        e0 = err_cnt;
        burst_len  = {8'd3, 8'd3, 8'd3, 8'd3};
        slave_mode = M_HOLD;
        do_reset();
        send_words(4'b1111, 16, 1'b1);  // two bursts per channel
        cyc = 0;
        while (!awvalid && cyc < TIMEOUT) begin
            @(negedge wr_clk);
            cyc++;
        end
        assert (awvalid) else begin
            $display("error at %0t: no AW request while awready was held low", $time);
            err_cnt++;
        end
        slave_mode = M_READY;
        wait_bursts(2 * NUM_CHAN);
        check_value("aw count", aw_chan_q.size(), 2 * NUM_CHAN);
        for (int k = 0; k < 2 * NUM_CHAN && k < aw_chan_q.size(); k++) begin
            check_value($sformatf("aw channel %0d", k), aw_chan_q[k], k % NUM_CHAN);
        end
        end_test("round robin", e0);
    endtask

    task automatic test_back_pressure();
        int         e0;
        int         remain [NUM_CHAN];
        int         total;
        int         left;
        user_word_t w;
        e0 = err_cnt;
        burst_len  = {8'd7, 8'd0, 8'd3, 8'd1};
        slave_mode = M_RAND;
        do_reset();
        total = 0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            remain[i] = 4 * (int'(burst_len[i]) + 1);  // two bursts per channel
            total += remain[i];
        end
        left = total;
        while (left > 0) begin
            @(negedge wr_clk);
            for (int i = 0; i < NUM_CHAN; i++) begin
                wr_en[i] = 1'b0;
                if (remain[i] > 0 && $urandom_range(1, 0) == 1) begin
                    w = $urandom;
                    wr_data[i] = w;
                    wr_en[i]   = 1'b1;
                    ref_q[i].push_back(w);
                    remain[i]--;
                    left--;
                end
            end
        end
        @(negedge wr_clk);
        wr_en = '0;
        wait_bursts(2 * NUM_CHAN);
        check_value("beat count", beat_cnt, total / 2);
        for (int i = 0; i < NUM_CHAN; i++) begin
            check_value($sformatf("words left ch%0d", i), ref_q[i].size(), 0);
        end
        slave_mode = M_READY;
        end_test("back-pressure", e0);
    endtask

    task automatic test_full_drop();
        int e0;
        int cyc;
        e0 = err_cnt;
        burst_len[2] = 8'd15;
        slave_mode   = M_HOLD;
        do_reset();
        send_words(4'b0100, 32, 1'b1);
        cyc = 0;
        while (!wr_full[2] && cyc < TIMEOUT) begin
            @(negedge wr_clk);
            cyc++;
        end
        assert (wr_full[2]) else begin
            $display("error at %0t: wr_full of channel 2 did not rise", $time);
            err_cnt++;
        end
        send_words(4'b0100, 2, 1'b0);   // this pair must be lost
        repeat (3) @(negedge wr_clk);
        check_value("wr_full[2]", wr_full[2], 1);
        slave_mode = M_READY;
        wait_bursts(1);
        check_value("beat count", beat_cnt, 16);
        check_value("words left ch2", ref_q[2].size(), 0);
        // a kept pair would show up at the head of the next burst
        send_words(4'b0100, 32, 1'b1);
        wait_bursts(2);
        check_value("beat count", beat_cnt, 32);
        check_value("words left ch2", ref_q[2].size(), 0);
        end_test("full and drop", e0);
    endtask

    initial begin
        void'($urandom(32'h2dd837f0));
        rst_n      = 1'b0;
        wr_en      = '0;
        wr_data    = '0;
        slave_mode = M_READY;
        resp_pend  = 0;
        err_cnt    = 0;
        test_cnt   = 0;
        fail_cnt   = 0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            beg_addr[i]  = axi_addr_t'(i) << 16;   // 64 KB region per channel
            end_addr[i]  = beg_addr[i] + 30'h0ffff;
            burst_len[i] = 8'd3;
        end
        test_reset_state();
        test_single_burst();
        test_addr_wrap();
        test_round_robin();
        test_back_pressure();
        test_full_drop();
        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
wr_path_pkg.sv
wr_req_if.sv
wr_chan_fifo.sv
wr_channel_ctrl.sv
wr_arbiter.sv
axi_wr_master.sv
multichannel_wr_top.sv
tb_multichannel_wr.sv
